// File: build.f
common/imu_pkg.sv
rtl/sample_capture.sv
formatter/sensor_data_formatter.sv
spi_slave/spi_tx_slave.sv
rtl/imu_spi_bridge_top.sv
testbench/imu_spi_bridge_asserts.sv
testbench/tb_imu_spi_bridge.sv

// File: common/imu_pkg.sv
package imu_pkg;

    // One IMU sample, quaternion first and then gyro
    // Field order here is also the order on the wire
    typedef struct packed {
        logic signed [15:0] quat_w;
        logic signed [15:0] quat_x;
        logic signed [15:0] quat_y;
        logic signed [15:0] quat_z;
        logic signed [15:0] gyro_x;
        logic signed [15:0] gyro_y;
        logic signed [15:0] gyro_z;
    } imu_sample_t;

    // First byte of every packet
    localparam logic [7:0] HEADER_BYTE = 8'hAA;

    // Header plus seven 16-bit values
    localparam int unsigned PACKET_BYTES = 15;

    // Formatter FSM
    // Header byte has its own state, the 14 data bytes share one
    typedef enum logic [1:0] {
        FMT_IDLE,
        FMT_SEND_HEADER,
        FMT_SEND_SENSOR
    } fmt_state_t;

    // SPI slave FSM
    // Idle while chip select is high, shifting while it is low
    typedef enum logic {
        SPI_IDLE,
        SPI_SHIFT
    } spi_state_t;

endpackage

// File: formatter/sensor_data_formatter.sv
`timescale 1ns/1ps

module sensor_data_formatter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 data_ready,
    input  imu_pkg::imu_sample_t sample,
    output logic                 tx_data_ready,
    output logic [7:0]           tx_data,
    input  logic                 tx_ack,
    output logic                 busy
);

    // Index of the last byte in the packet
    localparam logic [3:0] LAST_IDX = 4'(imu_pkg::PACKET_BYTES - 1);

    imu_pkg::fmt_state_t state;

    // Byte position inside the packet, 0 is the header
    logic [3:0] byte_idx;

    // Local copy of the sample for the whole packet
    imu_pkg::imu_sample_t sample_q;

    // Sample is taken once, when a packet starts
    // Capture may overwrite its copy while this one is sent
    always_ff @(posedge clk) begin
        if ((state == imu_pkg::FMT_IDLE) && data_ready) begin
            sample_q <= sample;
        end
    end

    // Byte mux
    // Header first, then each field low byte before high byte
    always_comb begin
        case (byte_idx)
            4'd0:    tx_data = imu_pkg::HEADER_BYTE;
            4'd1:    tx_data = sample_q.quat_w[7:0];
            4'd2:    tx_data = sample_q.quat_w[15:8];
            4'd3:    tx_data = sample_q.quat_x[7:0];
            4'd4:    tx_data = sample_q.quat_x[15:8];
            4'd5:    tx_data = sample_q.quat_y[7:0];
            4'd6:    tx_data = sample_q.quat_y[15:8];
            4'd7:    tx_data = sample_q.quat_z[7:0];
            4'd8:    tx_data = sample_q.quat_z[15:8];
            4'd9:    tx_data = sample_q.gyro_x[7:0];
            4'd10:   tx_data = sample_q.gyro_x[15:8];
            4'd11:   tx_data = sample_q.gyro_y[7:0];
            4'd12:   tx_data = sample_q.gyro_y[15:8];
            4'd13:   tx_data = sample_q.gyro_z[7:0];
            4'd14:   tx_data = sample_q.gyro_z[15:8];
            default: tx_data = 8'h00;
        endcase
    end

    // Packet FSM
    // Each byte is offered with tx_data_ready and held until acked
    // Ready goes low for one cycle between bytes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= imu_pkg::FMT_IDLE;
            byte_idx      <= 4'd0;
            tx_data_ready <= 1'b0;
            busy          <= 1'b0;
        end else begin
            case (state)
                imu_pkg::FMT_IDLE: begin
                    tx_data_ready <= 1'b0;
                    byte_idx      <= 4'd0;
                    if (data_ready) begin
                        // Busy rise tells capture the sample is taken
                        busy  <= 1'b1;
                        state <= imu_pkg::FMT_SEND_HEADER;
                    end
                end

                imu_pkg::FMT_SEND_HEADER: begin
                    if (!tx_data_ready) begin
                        // Header goes out one cycle after busy
                        tx_data_ready <= 1'b1;
                    end else if (tx_ack) begin
                        tx_data_ready <= 1'b0;
                        byte_idx      <= 4'd1;
                        state         <= imu_pkg::FMT_SEND_SENSOR;
                    end
                end

                imu_pkg::FMT_SEND_SENSOR: begin
                    if (!tx_data_ready) begin
                        tx_data_ready <= 1'b1;
                    end else if (tx_ack) begin
                        tx_data_ready <= 1'b0;
                        if (byte_idx == LAST_IDX) begin
                            // Ack of the last byte ends the packet
                            busy     <= 1'b0;
                            byte_idx <= 4'd0;
                            state    <= imu_pkg::FMT_IDLE;
                        end else begin
                            byte_idx <= byte_idx + 4'd1;
                        end
                    end
                end

                default: begin
                    tx_data_ready <= 1'b0;
                    busy          <= 1'b0;
                    byte_idx      <= 4'd0;
                    state         <= imu_pkg::FMT_IDLE;
                end
            endcase
        end
    end

endmodule

// File: rtl/imu_spi_bridge_top.sv
`timescale 1ns/1ps

module imu_spi_bridge_top #(
    parameter int unsigned SYNC_STAGES = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sample_strobe,
    input  logic               sample_valid,
    input  logic signed [15:0] quat_w,
    input  logic signed [15:0] quat_x,
    input  logic signed [15:0] quat_y,
    input  logic signed [15:0] quat_z,
    input  logic signed [15:0] gyro_x,
    input  logic signed [15:0] gyro_y,
    input  logic signed [15:0] gyro_z,
    input  logic               sclk,
    input  logic               cs_n,
    output logic               miso,
    output logic               busy,
    output logic [7:0]         drop_count
);

    imu_pkg::imu_sample_t sample_in;
    imu_pkg::imu_sample_t pending_sample;
    logic                 data_ready;

    // Formatter to SPI slave handshake
    logic       tx_data_ready;
    logic [7:0] tx_data;
    logic       tx_ack;

    // Input values gathered into one sample
    assign sample_in = '{
        quat_w: quat_w,
        quat_x: quat_x,
        quat_y: quat_y,
        quat_z: quat_z,
        gyro_x: gyro_x,
        gyro_y: gyro_y,
        gyro_z: gyro_z
    };

    sample_capture i_sample_capture (
        .clk            (clk),
        .rst_n          (rst_n),
        .sample_strobe  (sample_strobe),
        .sample_valid   (sample_valid),
        .sample_in      (sample_in),
        .formatter_busy (busy),
        .data_ready     (data_ready),
        .pending_sample (pending_sample),
        .drop_count     (drop_count)
    );

    sensor_data_formatter i_sensor_data_formatter (
        .clk           (clk),
        .rst_n         (rst_n),
        .data_ready    (data_ready),
        .sample        (pending_sample),
        .tx_data_ready (tx_data_ready),
        .tx_data       (tx_data),
        .tx_ack        (tx_ack),
        .busy          (busy)
    );

    // SPI pins cross into the clk domain inside the slave
    spi_tx_slave #(
        .SYNC_STAGES (SYNC_STAGES)
    ) i_spi_tx_slave (
        .clk           (clk),
        .rst_n         (rst_n),
        .sclk          (sclk),
        .cs_n          (cs_n),
        .miso          (miso),
        .tx_data_ready (tx_data_ready),
        .tx_data       (tx_data),
        .tx_ack        (tx_ack)
    );

endmodule

// File: rtl/sample_capture.sv
`timescale 1ns/1ps

module sample_capture (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sample_strobe,
    input  logic                 sample_valid,
    input  imu_pkg::imu_sample_t sample_in,
    input  logic                 formatter_busy,
    output logic                 data_ready,
    output imu_pkg::imu_sample_t pending_sample,
    output logic [7:0]           drop_count
);

    // Pending flag, drives data_ready directly
    logic pending;

    // Delayed copy of busy for edge detection
    logic busy_d;

    // Only strobes flagged valid are taken
    logic take_sample;

    // Formatter has latched the pending sample
    logic busy_rise;

    assign take_sample = sample_strobe && sample_valid;
    assign busy_rise   = formatter_busy && !busy_d;

    // Sample register, written on every valid strobe
    // A pending sample is simply overwritten by a newer one
    always_ff @(posedge clk) begin
        if (take_sample) begin
            pending_sample <= sample_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending    <= 1'b0;
            busy_d     <= 1'b0;
            drop_count <= 8'd0;
        end else begin
            busy_d <= formatter_busy;
            if (take_sample) begin
                // New sample keeps the flag set even on a busy edge
                pending <= 1'b1;
                // Overwrite of an untaken sample counts as a drop
                // On the busy edge the old one was already taken
                if (pending && !busy_rise) begin
                    // Counter sticks at its top value
                    if (drop_count != 8'hFF) begin
                        drop_count <= drop_count + 8'd1;
                    end
                end
            end else if (busy_rise) begin
                pending <= 1'b0;
            end
        end
    end

    assign data_ready = pending;

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_imu_spi_bridge \
    -f build.f \
    -Mdir obj_dir

./obj_dir/Vtb_imu_spi_bridge +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// File: spi_slave/spi_tx_slave.sv
`timescale 1ns/1ps

module spi_tx_slave #(
    parameter int unsigned SYNC_STAGES = 2
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sclk,
    input  logic       cs_n,
    output logic       miso,
    input  logic       tx_data_ready,
    input  logic [7:0] tx_data,
    output logic       tx_ack
);

    // Synchronizer chains, pin enters at bit 0
    logic [SYNC_STAGES-1:0] sclk_sync;
    logic [SYNC_STAGES-1:0] cs_sync;

    // Previous synchronized levels
    logic sclk_d;
    logic cs_d;

    logic sclk_rise;
    logic sclk_fall;
    logic cs_fall;
    logic cs_rise;

    imu_pkg::spi_state_t state;

    // Rising edges seen in the current byte, 0 to 8
    logic [3:0] bit_cnt;

    // Bytes loaded since chip select fell
    logic [3:0] byte_cnt;

    logic [7:0] shift_reg;

    // Load points and the byte taken from the formatter
    logic start_load;
    logic next_load;
    logic load;
    logic take;
    logic shift_en;

    assign sclk_rise = sclk_sync[SYNC_STAGES-1] && !sclk_d;
    assign sclk_fall = !sclk_sync[SYNC_STAGES-1] && sclk_d;
    assign cs_fall   = !cs_sync[SYNC_STAGES-1] && cs_d;
    assign cs_rise   = cs_sync[SYNC_STAGES-1] && !cs_d;

    // First byte of a frame loads as chip select falls
    assign start_load = (state == imu_pkg::SPI_IDLE) && cs_fall;

    // Next byte loads on the falling edge after the 8th rising edge
    // A frame carries one packet, so loading stops after its last byte
    assign next_load = (state == imu_pkg::SPI_SHIFT) && !cs_rise && sclk_fall &&
                       (bit_cnt == 4'd8) && (byte_cnt < 4'(imu_pkg::PACKET_BYTES));

    assign load     = start_load || next_load;
    assign take     = load && tx_data_ready;
    assign shift_en = (state == imu_pkg::SPI_SHIFT) && !cs_rise && sclk_fall && !next_load;

    // Shift register, MSB leaves first
    // Missing formatter data goes out as zeros
    always_ff @(posedge clk) begin
        if (load) begin
            shift_reg <= take ? tx_data : 8'h00;
        end else if (shift_en) begin
            shift_reg <= {shift_reg[6:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Mode 0 idle levels, clock low and select high
            sclk_sync <= '0;
            cs_sync   <= '1;
            sclk_d    <= 1'b0;
            cs_d      <= 1'b1;
            state     <= imu_pkg::SPI_IDLE;
            bit_cnt   <= 4'd0;
            byte_cnt  <= 4'd0;
            tx_ack    <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[SYNC_STAGES-2:0], sclk};
            cs_sync   <= {cs_sync[SYNC_STAGES-2:0], cs_n};
            sclk_d    <= sclk_sync[SYNC_STAGES-1];
            cs_d      <= cs_sync[SYNC_STAGES-1];

            // One pulse per byte really taken
            tx_ack <= take;

            case (state)
                imu_pkg::SPI_IDLE: begin
                    if (cs_fall) begin
                        bit_cnt  <= 4'd0;
                        byte_cnt <= 4'd1;
                        state    <= imu_pkg::SPI_SHIFT;
                    end
                end

                imu_pkg::SPI_SHIFT: begin
                    if (cs_rise) begin
                        state <= imu_pkg::SPI_IDLE;
                    end else if (sclk_rise) begin
                        // Master samples here, count the bit
                        if (bit_cnt != 4'd8) begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end else if (sclk_fall && (bit_cnt == 4'd8)) begin
                        bit_cnt <= 4'd0;
                        if (next_load) begin
                            byte_cnt <= byte_cnt + 4'd1;
                        end
                    end
                end

                default: begin
                    state <= imu_pkg::SPI_IDLE;
                end
            endcase
        end
    end

    // Line held low outside a frame
    assign miso = (state == imu_pkg::SPI_SHIFT) ? shift_reg[7] : 1'b0;

endmodule

// File: testbench/imu_spi_bridge_asserts.sv
`timescale 1ns/1ps

module imu_spi_bridge_asserts (
    input logic                clk,
    input logic                rst_n,
    input logic                tx_data_ready,
    input logic [7:0]          tx_data,
    input logic                tx_ack,
    input logic                busy,
    input imu_pkg::fmt_state_t state,
    input logic [3:0]          byte_idx
);

    // Failures seen so far, read by the testbench at the end
    int fail_count = 0;

    // Offered byte holds until the slave takes it
    a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_data_ready && !tx_ack) |=> $stable(tx_data))
        else begin
            fail_count++;
            $error("tx_data changed while waiting for tx_ack");
        end

    a_ack_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
        tx_ack |-> tx_data_ready)
        else begin
            fail_count++;
            $error("tx_ack without tx_data_ready");
        end

    // Formatter stays idle through the first clock out of reset
    a_reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |=> (!busy && (state == imu_pkg::FMT_IDLE)))
        else begin
            fail_count++;
            $error("formatter not idle after reset");
        end

    a_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
        byte_idx < 4'(imu_pkg::PACKET_BYTES))
        else begin
            fail_count++;
            $error("byte index past the packet end");
        end

endmodule

bind sensor_data_formatter imu_spi_bridge_asserts i_formatter_asserts (
    .clk           (clk),
    .rst_n         (rst_n),
    .tx_data_ready (tx_data_ready),
    .tx_data       (tx_data),
    .tx_ack        (tx_ack),
    .busy          (busy),
    .state         (state),
    .byte_idx      (byte_idx)
);

// File: testbench/tb_imu_spi_bridge.sv
`timescale 1ns/1ps

module tb_imu_spi_bridge;

    // SPI half period in clk cycles
    localparam int HALF_SCLK = 6;
    // Frames clocked over the whole run, tests 1 to 6
    localparam int NUM_FRAMES = 1 + 3 + 2 + 2 + 50;
    localparam int TIMEOUT_CYCLES =
        NUM_FRAMES * int'(imu_pkg::PACKET_BYTES) * 8 * 2 * HALF_SCLK + 2000;

    logic clk;
    logic rst_n;
    logic sample_strobe;
    logic sample_valid;
    logic signed [15:0] quat_w, quat_x, quat_y, quat_z;
    logic signed [15:0] gyro_x, gyro_y, gyro_z;
    logic sclk;
    logic cs_n;
    logic miso;
    logic busy;
    logic [7:0] drop_count;

    logic [31:0] lfsr_state = 32'd32;
    // Model: sample waiting in capture, samples taken by the formatter
    imu_pkg::imu_sample_t pend_q[$];
    imu_pkg::imu_sample_t expect_q[$];
    logic [7:0] model_drops = 8'h00;
    logic [7:0] rx_bytes[$];
    logic busy_seen = 1'b0;
    int busy_rises = 0;
    int checks = 0;
    int errors = 0;
    int cycle_cnt = 0;

    imu_spi_bridge_top #(
        .SYNC_STAGES (2)
    ) i_imu_spi_bridge_top (
        .clk (clk), .rst_n (rst_n),
        .sample_strobe (sample_strobe), .sample_valid (sample_valid),
        .quat_w (quat_w), .quat_x (quat_x), .quat_y (quat_y), .quat_z (quat_z),
        .gyro_x (gyro_x), .gyro_y (gyro_y), .gyro_z (gyro_z),
        .sclk (sclk), .cs_n (cs_n), .miso (miso),
        .busy (busy), .drop_count (drop_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Busy rise means the formatter took the pending sample
    always @(negedge clk) begin
        if (busy && !busy_seen) begin
            busy_rises = busy_rises + 1;
            if (pend_q.size() != 0) begin
                expect_q.push_back(pend_q.pop_front());
            end else begin
                $display("Busy rose while the model holds no pending sample");
                errors++;
            end
        end
        busy_seen = busy;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [15:0] rand_word();
        logic [15:0] v;
        v = 16'h0000;
        for (int i = 0; i < 16; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // First word drawn lands in quat_w
    function automatic imu_pkg::imu_sample_t rand_sample();
        imu_pkg::imu_sample_t s;
        s = '0;
        for (int i = 0; i < 7; i++) begin
            s = {s[95:0], rand_word()};
        end
        return s;
    endfunction

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_sample(input imu_pkg::imu_sample_t got, input imu_pkg::imu_sample_t exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED sample: got 0x%h, expected 0x%h", got, exp);
            errors++;
        end
    endtask

    task automatic check_drops(input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED drop_count: got 0x%h, expected 0x%h", got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // One strobe cycle, model follows the overwrite rule
    task automatic apply_sample(input imu_pkg::imu_sample_t s, input logic valid);
        @(posedge clk);
        #1;
        sample_strobe = 1'b1;
        sample_valid  = valid;
        {quat_w, quat_x, quat_y, quat_z, gyro_x, gyro_y, gyro_z} = s;
        if (valid && (pend_q.size() != 0)) begin
            if (model_drops != 8'hFF) begin
                model_drops++;
            end
            pend_q[0] = s;
        end else if (valid) begin
            pend_q.push_back(s);
        end
        @(posedge clk);
        #1;
        sample_strobe = 1'b0;
        sample_valid  = 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Header is offered one cycle after busy
    task automatic wait_packet();
        while (!busy) wait_cycles(1);
        wait_cycles(2);
    endtask

    // SPI mode 0 master, one frame of 15 bytes, miso taken on rising sclk
    task automatic read_frame();
        logic [7:0] b;
        rx_bytes.delete();
        wait_cycles(1);
        cs_n = 1'b0;
        wait_cycles(HALF_SCLK);
        for (int n = 0; n < int'(imu_pkg::PACKET_BYTES); n++) begin
            b = 8'h00;
            for (int k = 0; k < 8; k++) begin
                sclk = 1'b1;
                b = {b[6:0], miso};
                wait_cycles(HALF_SCLK);
                sclk = 1'b0;
                wait_cycles(HALF_SCLK);
            end
            rx_bytes.push_back(b);
        end
        cs_n = 1'b1;
        wait_cycles(2 * HALF_SCLK);
    endtask

    // Header, then each field low byte first
    task automatic check_packet();
        imu_pkg::imu_sample_t got;
        got = '0;
        check_byte("header", rx_bytes[0], imu_pkg::HEADER_BYTE);
        for (int i = 0; i < 7; i++) begin
            got = {got[95:0], rx_bytes[2*i+2], rx_bytes[2*i+1]};
        end
        if (expect_q.size() == 0) begin
            $display("A packet arrived with no sample expected by the model");
            errors++;
        end else begin
            check_sample(got, expect_q.pop_front());
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        $display("Test %s finished with %0d errors", name, errors - err_start);
    endtask

    initial begin
        int err0;
        int rises0;
        rst_n         = 1'b0;
        sample_strobe = 1'b0;
        sample_valid  = 1'b0;
        {quat_w, quat_x, quat_y, quat_z, gyro_x, gyro_y, gyro_z} = '0;
        sclk          = 1'b0;
        cs_n          = 1'b1;
        wait_cycles(4);
        rst_n = 1'b1;
        check_drops(drop_count, 8'h00);

        err0 = errors;
        apply_sample(rand_sample(), 1'b1);
        wait_packet();
        read_frame();
        check_packet();
        report_test("1 single packet", err0);

        err0   = errors;
        rises0 = busy_rises;
        repeat (5) apply_sample(rand_sample(), 1'b0);
        wait_cycles(20);
        check_flag("busy", busy, 1'b0);
        if (busy_rises != rises0) begin
            $display("Busy rose after strobes without sample_valid");
            errors++;
        end
        check_drops(drop_count, 8'h00);
        report_test("2 invalid strobes", err0);

        // Overwrites pile up behind a packet in flight
        err0 = errors;
        apply_sample(rand_sample(), 1'b1);
        wait_packet();
        fork
            read_frame();
            begin
                wait_cycles(20);
                repeat (3) apply_sample(rand_sample(), 1'b1);
            end
        join
        check_packet();
        check_drops(drop_count, model_drops);
        wait_packet();
        fork
            read_frame();
            begin
                wait_cycles(20);
                repeat (260) apply_sample(rand_sample(), 1'b1);
            end
        join
        check_packet();
        check_drops(drop_count, model_drops);
        check_drops(drop_count, 8'hFF);
        wait_packet();
        read_frame();
        check_packet();
        report_test("3 overwrite and drops", err0);

        err0 = errors;
        apply_sample(rand_sample(), 1'b1);
        wait_packet();
        fork
            read_frame();
            begin
                wait_cycles(40);
                apply_sample(rand_sample(), 1'b1);
            end
        join
        check_packet();
        wait_packet();
        read_frame();
        check_packet();
        report_test("4 strobe during packet", err0);

        // No sample pending, the slave sends zeros
        err0   = errors;
        rises0 = busy_rises;
        read_frame();
        foreach (rx_bytes[n]) begin
            check_byte("idle miso byte", rx_bytes[n], 8'h00);
        end
        if (busy_rises != rises0) begin
            $display("Busy rose during a frame with no sample pending");
            errors++;
        end
        apply_sample(rand_sample(), 1'b1);
        wait_packet();
        read_frame();
        check_packet();
        report_test("5 idle frame", err0);

        err0 = errors;
        repeat (50) begin
            apply_sample(rand_sample(), 1'b1);
            wait_packet();
            read_frame();
            check_packet();
            check_flag("busy", busy, 1'b0);
        end
        report_test("6 random packets", err0);

        errors = errors
            + i_imu_spi_bridge_top.i_sensor_data_formatter.i_formatter_asserts.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
